// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = lsu_tb
RTL_TOP  = lsu_top
FILELIST = project.f
OBJ_DIR  = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "All tests passed"

lint:
	$(TOOL) --lint-only -Wall --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: project.f
rtl/lsu_pkg.sv
rtl/lsu_req_if.sv
rtl/lsu_rsp_if.sv
rtl/lsu_decode.sv
rtl/l1d_cache.sv
rtl/lsu_execute.sv
rtl/lsu_result.sv
rtl/lsu_top.sv
verif/axi_lite_mem_model.sv
verif/lsu_tb.sv

// File: rtl/l1d_cache.sv
`timescale 1ns/100ps

module l1d_cache
  import lsu_pkg::*;
#(
  parameter int L1D_INDEX_W = 6
)
(
  input  logic  clk,
  input  logic  reset_i,
  input  addr_t lookup_addr_i,
  output logic  hit_o,
  output data_t hit_data_o,
  input  logic  fill_i,
  input  data_t fill_data_i,
  input  logic  inval_i
);

  localparam int TAG_W = 30 - L1D_INDEX_W;
  localparam int LINES = 1 << L1D_INDEX_W;

  logic [TAG_W-1:0]       tag_mem [LINES];
  data_t                  data_mem [LINES];
  logic [LINES-1:0]       valid_q;
  logic [L1D_INDEX_W-1:0] idx;
  logic [TAG_W-1:0]       tag;

  assign idx = lookup_addr_i[L1D_INDEX_W+1:2];
  assign tag = lookup_addr_i[31:L1D_INDEX_W+2];

  assign hit_o      = valid_q[idx] && (tag_mem[idx] == tag);
  assign hit_data_o = data_mem[idx];

  always_ff @(posedge clk)
  begin
    if (reset_i)
      valid_q <= '0;
    else if (fill_i)
      valid_q[idx] <= 1'b1;
    else if (inval_i)
      valid_q[idx] <= 1'b0;
  end

  // line payload
  always_ff @(posedge clk)
  begin
    if (fill_i)
    begin
      tag_mem[idx]  <= tag;
      data_mem[idx] <= fill_data_i;
    end
  end

endmodule

// File: rtl/lsu_decode.sv
`timescale 1ns/100ps

module lsu_decode
  import lsu_pkg::*;
(
  input  logic      clk,
  input  logic      reset_i,
  input  logic      req_valid_i,
  output logic      req_ready_o,
  input  lsu_op_t   req_op_i,
  input  addr_t     req_addr_i,
  input  data_t     req_wdata_i,
  lsu_req_if.source req
);

  logic       valid_q;
  logic       accept;
  logic       dec_store;
  logic       dec_signed;
  mem_size_t  dec_size;
  strb_t      dec_mask;
  logic [1:0] off;

  assign off = req_addr_i[1:0];

  // empty, or draining this cycle
  assign req_ready_o = !valid_q || req.ready;
  assign accept = req_valid_i && req_ready_o;
  assign req.valid = valid_q;

  always_comb
  begin
    dec_store  = 1'b0;
    dec_signed = 1'b0;
    dec_size   = SIZE_WORD;
    dec_mask   = 4'h0;
    case (req_op_i)
      OP_LB:
      begin
        dec_size   = SIZE_BYTE;
        dec_signed = 1'b1;
      end
      OP_LBU: dec_size = SIZE_BYTE;
      OP_LH:
      begin
        dec_size   = SIZE_HALF;
        dec_signed = 1'b1;
      end
      OP_LHU: dec_size = SIZE_HALF;
      OP_LW:  dec_size = SIZE_WORD;
      OP_SB:
      begin
        dec_store = 1'b1;
        dec_size  = SIZE_BYTE;
        dec_mask  = 4'h1;
      end
      OP_SH:
      begin
        dec_store = 1'b1;
        dec_size  = SIZE_HALF;
        dec_mask  = 4'h3;
      end
      OP_SW:
      begin
        dec_store = 1'b1;
        dec_mask  = 4'hf;
      end
      // unknown op behaves as a store that writes nothing
      default: dec_store = 1'b1;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset_i)
      valid_q <= 1'b0;
    else if (accept)
      valid_q <= 1'b1;
    else if (req.ready)
      valid_q <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      req.word_addr <= {req_addr_i[31:2], 2'b00};
      req.byte_off  <= off;
      req.is_store  <= dec_store;
      req.size      <= dec_size;
      req.is_signed <= dec_signed;
      req.wdata     <= req_wdata_i << {off, 3'b000};
      req.wstrb     <= dec_mask << off;
    end
  end

endmodule

// File: rtl/lsu_execute.sv
`timescale 1ns/100ps

module lsu_execute
  import lsu_pkg::*;
#(
  parameter int L1D_INDEX_W = 6
)
(
  input  logic      clk,
  input  logic      reset_i,
  lsu_req_if.sink   req,
  lsu_rsp_if.source rsp,
  output addr_t     m_araddr_o,
  output logic      m_arvalid_o,
  input  logic      m_arready_i,
  input  data_t     m_rdata_i,
  input  logic      m_rvalid_i,
  output logic      m_rready_o,
  output addr_t     m_awaddr_o,
  output logic      m_awvalid_o,
  input  logic      m_awready_i,
  output data_t     m_wdata_o,
  output strb_t     m_wstrb_o,
  output logic      m_wvalid_o,
  input  logic      m_wready_i,
  input  logic      m_bvalid_i,
  output logic      m_bready_o
);

  typedef enum logic [2:0] {IDLE, LOOKUP, AR, R, WRITE, B, RESP} state_t;

  state_t     state_q;
  state_t     state_d;
  logic       aw_pend_q;
  logic       w_pend_q;
  logic       aw_done;
  logic       w_done;
  addr_t      addr_q;
  logic [1:0] off_q;
  mem_size_t  size_q;
  logic       signed_q;
  logic       store_q;
  data_t      wdata_q;
  strb_t      wstrb_q;
  data_t      word_q;
  logic       hit;
  data_t      hit_data;
  logic       fill;
  logic       inval;

  assign fill  = (state_q == R) && m_rvalid_i;
  assign inval = (state_q == LOOKUP) && store_q;

  l1d_cache #(
    .L1D_INDEX_W(L1D_INDEX_W)
  ) u_cache (
    .clk          (clk),
    .reset_i      (reset_i),
    .lookup_addr_i(addr_q),
    .hit_o        (hit),
    .hit_data_o   (hit_data),
    .fill_i       (fill),
    .fill_data_i  (m_rdata_i),
    .inval_i      (inval)
  );

  assign req.ready = (state_q == IDLE);

  assign m_araddr_o  = addr_q;
  assign m_arvalid_o = (state_q == AR);
  assign m_rready_o  = (state_q == R);
  assign m_awaddr_o  = addr_q;
  assign m_awvalid_o = (state_q == WRITE) && aw_pend_q;
  assign m_wdata_o   = wdata_q;
  assign m_wstrb_o   = wstrb_q;
  assign m_wvalid_o  = (state_q == WRITE) && w_pend_q;
  assign m_bready_o  = (state_q == B);

  // either channel may finish first
  assign aw_done = !aw_pend_q || m_awready_i;
  assign w_done  = !w_pend_q || m_wready_i;

  assign rsp.valid     = (state_q == RESP);
  assign rsp.word      = word_q;
  assign rsp.byte_off  = off_q;
  assign rsp.size      = size_q;
  assign rsp.is_signed = signed_q;
  assign rsp.is_store  = store_q;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      IDLE:
        if (req.valid)
          state_d = LOOKUP;
      LOOKUP:
        if (store_q)
          state_d = WRITE;
        else if (hit)
          state_d = RESP;
        else
          state_d = AR;
      AR:
        if (m_arready_i)
          state_d = R;
      R:
        if (m_rvalid_i)
          state_d = RESP;
      WRITE:
        if (aw_done && w_done)
          state_d = B;
      B:
        if (m_bvalid_i)
          state_d = RESP;
      RESP:
        if (rsp.ready)
          state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset_i)
    begin
      state_q   <= IDLE;
      aw_pend_q <= 1'b0;
      w_pend_q  <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      if (inval)
      begin
        aw_pend_q <= 1'b1;
        w_pend_q  <= 1'b1;
      end
      else
      begin
        if (m_awvalid_o && m_awready_i)
          aw_pend_q <= 1'b0;
        if (m_wvalid_o && m_wready_i)
          w_pend_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (req.valid && req.ready)
    begin
      addr_q   <= req.word_addr;
      off_q    <= req.byte_off;
      size_q   <= req.size;
      signed_q <= req.is_signed;
      store_q  <= req.is_store;
      wdata_q  <= req.wdata;
      wstrb_q  <= req.wstrb;
    end
    if ((state_q == LOOKUP) && !store_q && hit)
      word_q <= hit_data;
    else if (fill)
      word_q <= m_rdata_i;
  end

endmodule

// File: rtl/lsu_pkg.sv
package lsu_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  typedef logic [3:0]  lsu_op_t;
  typedef logic [1:0]  mem_size_t;

  // loads
  localparam lsu_op_t OP_LB  = 4'd0;
  localparam lsu_op_t OP_LH  = 4'd1;
  localparam lsu_op_t OP_LW  = 4'd2;
  localparam lsu_op_t OP_LBU = 4'd4;
  localparam lsu_op_t OP_LHU = 4'd5;

  // stores
  localparam lsu_op_t OP_SB  = 4'd8;
  localparam lsu_op_t OP_SH  = 4'd9;
  localparam lsu_op_t OP_SW  = 4'd10;

  localparam mem_size_t SIZE_BYTE = 2'd0;
  localparam mem_size_t SIZE_HALF = 2'd1;
  localparam mem_size_t SIZE_WORD = 2'd2;

endpackage

// File: rtl/lsu_req_if.sv
`timescale 1ns/100ps

interface lsu_req_if
  import lsu_pkg::*;
();
  logic      valid;
  logic      ready;
  addr_t     word_addr;
  logic [1:0] byte_off;
  logic      is_store;
  mem_size_t size;
  logic      is_signed;
  data_t     wdata;
  strb_t     wstrb;

  modport source (output valid, word_addr, byte_off, is_store, size, is_signed, wdata, wstrb,
                  input ready);
  modport sink (input valid, word_addr, byte_off, is_store, size, is_signed, wdata, wstrb,
                output ready);
endinterface

// File: rtl/lsu_result.sv
`timescale 1ns/100ps

module lsu_result
  import lsu_pkg::*;
(
  input  logic    clk,
  input  logic    reset_i,
  lsu_rsp_if.sink rsp,
  output logic    resp_valid_o,
  input  logic    resp_ready_i,
  output data_t   resp_rdata_o
);

  logic  valid_q;
  data_t rdata_q;
  data_t shifted;
  data_t ext;

  assign rsp.ready    = !valid_q || resp_ready_i;
  assign resp_valid_o = valid_q;
  assign resp_rdata_o = rdata_q;

  // addressed bytes down to lane 0
  assign shifted = rsp.word >> {rsp.byte_off, 3'b000};

  always_comb
  begin
    if (rsp.is_store)
      ext = '0;
    else if (rsp.size == SIZE_BYTE)
      ext = {{24{rsp.is_signed && shifted[7]}}, shifted[7:0]};
    else if (rsp.size == SIZE_HALF)
      ext = {{16{rsp.is_signed && shifted[15]}}, shifted[15:0]};
    else
      ext = rsp.word;
  end

  always_ff @(posedge clk)
  begin
    if (reset_i)
      valid_q <= 1'b0;
    else if (rsp.valid && rsp.ready)
      valid_q <= 1'b1;
    else if (resp_ready_i)
      valid_q <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (rsp.valid && rsp.ready)
      rdata_q <= ext;
  end

endmodule

// File: rtl/lsu_rsp_if.sv
`timescale 1ns/100ps

interface lsu_rsp_if
  import lsu_pkg::*;
();
  logic       valid;
  logic       ready;
  data_t      word;
  logic [1:0] byte_off;
  mem_size_t  size;
  logic       is_signed;
  logic       is_store;

  modport source (output valid, word, byte_off, size, is_signed, is_store, input ready);
  modport sink (input valid, word, byte_off, size, is_signed, is_store, output ready);
endinterface

// File: rtl/lsu_top.sv
`timescale 1ns/100ps

module lsu_top
  import lsu_pkg::*;
#(
  parameter int L1D_INDEX_W = 6
)
(
  input  logic    clk,
  input  logic    reset_i,
  input  logic    req_valid_i,
  output logic    req_ready_o,
  input  lsu_op_t req_op_i,
  input  addr_t   req_addr_i,
  input  data_t   req_wdata_i,
  output logic    resp_valid_o,
  input  logic    resp_ready_i,
  output data_t   resp_rdata_o,
  output addr_t   m_araddr_o,
  output logic    m_arvalid_o,
  input  logic    m_arready_i,
  input  data_t   m_rdata_i,
  input  logic    m_rvalid_i,
  output logic    m_rready_o,
  output addr_t   m_awaddr_o,
  output logic    m_awvalid_o,
  input  logic    m_awready_i,
  output data_t   m_wdata_o,
  output strb_t   m_wstrb_o,
  output logic    m_wvalid_o,
  input  logic    m_wready_i,
  input  logic    m_bvalid_i,
  output logic    m_bready_o
);

  lsu_req_if req_if ();
  lsu_rsp_if rsp_if ();

  lsu_decode u_decode (
    .clk        (clk),
    .reset_i    (reset_i),
    .req_valid_i(req_valid_i),
    .req_ready_o(req_ready_o),
    .req_op_i   (req_op_i),
    .req_addr_i (req_addr_i),
    .req_wdata_i(req_wdata_i),
    .req        (req_if.source)
  );

  lsu_execute #(
    .L1D_INDEX_W(L1D_INDEX_W)
  ) u_execute (
    .clk        (clk),
    .reset_i    (reset_i),
    .req        (req_if.sink),
    .rsp        (rsp_if.source),
    .m_araddr_o (m_araddr_o),
    .m_arvalid_o(m_arvalid_o),
    .m_arready_i(m_arready_i),
    .m_rdata_i  (m_rdata_i),
    .m_rvalid_i (m_rvalid_i),
    .m_rready_o (m_rready_o),
    .m_awaddr_o (m_awaddr_o),
    .m_awvalid_o(m_awvalid_o),
    .m_awready_i(m_awready_i),
    .m_wdata_o  (m_wdata_o),
    .m_wstrb_o  (m_wstrb_o),
    .m_wvalid_o (m_wvalid_o),
    .m_wready_i (m_wready_i),
    .m_bvalid_i (m_bvalid_i),
    .m_bready_o (m_bready_o)
  );

  lsu_result u_result (
    .clk         (clk),
    .reset_i     (reset_i),
    .rsp         (rsp_if.sink),
    .resp_valid_o(resp_valid_o),
    .resp_ready_i(resp_ready_i),
    .resp_rdata_o(resp_rdata_o)
  );

endmodule

// File: verif/axi_lite_mem_model.sv
`timescale 1ns/100ps

// raises go_o after 0 to 3 cycles of a pending request, holds it until done
module ready_delay (
  input  logic       clk,
  input  logic       reset_i,
  input  logic       req_i,
  input  logic       done_i,
  input  logic [1:0] delay_i,
  output logic       go_o
);

  logic       armed_q;
  logic [1:0] count_q;

  assign go_o = req_i && (armed_q ? (count_q == 2'd0) : (delay_i == 2'd0));

  always @(posedge clk)
  begin
    if (reset_i || done_i)
      armed_q <= 1'b0;
    else if (req_i && !armed_q)
    begin
      armed_q <= 1'b1;
      count_q <= (delay_i == 2'd0) ? 2'd0 : delay_i - 2'd1;
    end
    else if (req_i && count_q != 2'd0)
      count_q <= count_q - 2'd1;
  end

endmodule

module axi_lite_mem_model (
  input  logic        clk,
  input  logic        reset_i,
  input  logic [9:0]  delay_i,
  input  logic [31:0] araddr_i,
  input  logic        arvalid_i,
  output logic        arready_o,
  output logic [31:0] rdata_o,
  output logic        rvalid_o,
  input  logic        rready_i,
  input  logic [31:0] awaddr_i,
  input  logic        awvalid_i,
  output logic        awready_o,
  input  logic [31:0] wdata_i,
  input  logic [3:0]  wstrb_i,
  input  logic        wvalid_i,
  output logic        wready_o,
  output logic        bvalid_o,
  input  logic        bready_i
);

  logic [31:0] mem [256];
  logic        r_pend_q;
  logic        aw_seen_q;
  logic        w_seen_q;
  logic        b_pend_q;
  logic [31:0] raddr_q;
  logic [31:0] awaddr_q;
  logic [31:0] wdata_q;
  logic [3:0]  wstrb_q;

  // same pattern as the shadow memory of the testbench
  initial
  begin
    for (int i = 0; i < 256; i++)
      mem[i] <= 32'(i) * 32'h9e37_79b1 ^ 32'h5a5a_0f0f;
  end

  ready_delay u_ar (
    .clk(clk), .reset_i(reset_i), .req_i(arvalid_i && !r_pend_q),
    .done_i(arvalid_i && arready_o), .delay_i(delay_i[1:0]), .go_o(arready_o)
  );
  ready_delay u_r (
    .clk(clk), .reset_i(reset_i), .req_i(r_pend_q),
    .done_i(rvalid_o && rready_i), .delay_i(delay_i[3:2]), .go_o(rvalid_o)
  );
  ready_delay u_aw (
    .clk(clk), .reset_i(reset_i), .req_i(awvalid_i && !aw_seen_q),
    .done_i(awvalid_i && awready_o), .delay_i(delay_i[5:4]), .go_o(awready_o)
  );
  ready_delay u_w (
    .clk(clk), .reset_i(reset_i), .req_i(wvalid_i && !w_seen_q),
    .done_i(wvalid_i && wready_o), .delay_i(delay_i[7:6]), .go_o(wready_o)
  );
  ready_delay u_b (
    .clk(clk), .reset_i(reset_i), .req_i(b_pend_q),
    .done_i(bvalid_o && bready_i), .delay_i(delay_i[9:8]), .go_o(bvalid_o)
  );

  assign rdata_o = mem[raddr_q[9:2]];

  always @(posedge clk)
  begin
    if (reset_i)
    begin
      r_pend_q  <= 1'b0;
      aw_seen_q <= 1'b0;
      w_seen_q  <= 1'b0;
      b_pend_q  <= 1'b0;
    end
    else
    begin
      if (arvalid_i && arready_o)
      begin
        r_pend_q <= 1'b1;
        raddr_q  <= araddr_i;
      end
      else if (rvalid_o && rready_i)
        r_pend_q <= 1'b0;
      if (awvalid_i && awready_o)
      begin
        aw_seen_q <= 1'b1;
        awaddr_q  <= awaddr_i;
      end
      if (wvalid_i && wready_o)
      begin
        w_seen_q <= 1'b1;
        wdata_q  <= wdata_i;
        wstrb_q  <= wstrb_i;
      end
      // commit once address and data are both in
      if (aw_seen_q && w_seen_q)
      begin
        for (int i = 0; i < 4; i++)
          if (wstrb_q[i])
            mem[awaddr_q[9:2]][8*i +: 8] <= wdata_q[8*i +: 8];
        aw_seen_q <= 1'b0;
        w_seen_q  <= 1'b0;
        b_pend_q  <= 1'b1;
      end
      if (bvalid_o && bready_i)
        b_pend_q <= 1'b0;
    end
  end

endmodule

// File: verif/lsu_tb.sv
`timescale 1ns/100ps

module lsu_tb
  import lsu_pkg::*;
();

  localparam int NUM_REQ   = 400;
  localparam int CLK_NS    = 10;
  localparam int LIMIT_CYC = NUM_REQ * 40;
  localparam int MEM_WORDS = 256;
  localparam int LINES     = 64;

  typedef struct packed {
    lsu_op_t op;
    addr_t   addr;
    data_t   data;
    logic    ar;
  } expect_t;

  logic       clk;
  logic       reset_i;
  logic       req_valid;
  logic       req_ready;
  lsu_op_t    req_op;
  addr_t      req_addr;
  data_t      req_wdata;
  logic       resp_valid;
  logic       resp_ready;
  data_t      resp_rdata;
  addr_t      araddr;
  logic       arvalid;
  logic       arready;
  data_t      rdata;
  logic       rvalid;
  logic       rready;
  addr_t      awaddr;
  logic       awvalid;
  logic       awready;
  data_t      wdata;
  strb_t      wstrb;
  logic       wvalid;
  logic       wready;
  logic       bvalid;
  logic       bready;
  logic [9:0] delays;

  logic [31:0] lfsr_q;
  data_t       shadow [MEM_WORDS];
  logic        mvalid [LINES];
  logic [23:0] mtag [LINES];
  expect_t     exp_q [$];
  int          ar_seen [NUM_REQ];
  int          sent;
  int          resp_count;
  int          errors;
  int          checks;
  logic        hold_q;
  data_t       hold_data;

  lsu_top #(
    .L1D_INDEX_W(6)
  ) DUT (
    .clk(clk), .reset_i(reset_i),
    .req_valid_i(req_valid), .req_ready_o(req_ready), .req_op_i(req_op),
    .req_addr_i(req_addr), .req_wdata_i(req_wdata),
    .resp_valid_o(resp_valid), .resp_ready_i(resp_ready), .resp_rdata_o(resp_rdata),
    .m_araddr_o(araddr), .m_arvalid_o(arvalid), .m_arready_i(arready),
    .m_rdata_i(rdata), .m_rvalid_i(rvalid), .m_rready_o(rready),
    .m_awaddr_o(awaddr), .m_awvalid_o(awvalid), .m_awready_i(awready),
    .m_wdata_o(wdata), .m_wstrb_o(wstrb), .m_wvalid_o(wvalid), .m_wready_i(wready),
    .m_bvalid_i(bvalid), .m_bready_o(bready)
  );

  axi_lite_mem_model u_mem (
    .clk(clk), .reset_i(reset_i), .delay_i(delays),
    .araddr_i(araddr), .arvalid_i(arvalid), .arready_o(arready),
    .rdata_o(rdata), .rvalid_o(rvalid), .rready_i(rready),
    .awaddr_i(awaddr), .awvalid_i(awvalid), .awready_o(awready),
    .wdata_i(wdata), .wstrb_i(wstrb), .wvalid_i(wvalid), .wready_o(wready),
    .bvalid_o(bvalid), .bready_i(bready)
  );

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);
    end
    return v;
  endfunction

  function automatic data_t fill_word(input int i);
    return 32'(i) * 32'h9e37_79b1 ^ 32'h5a5a_0f0f;
  endfunction

  function automatic data_t load_value(input lsu_op_t op, input data_t word,
                                       input logic [1:0] off);
    data_t sh;
    sh = word >> {off, 3'b000};
    case (op)
      OP_LB:   return {{24{sh[7]}}, sh[7:0]};
      OP_LBU:  return {24'h0, sh[7:0]};
      OP_LH:   return {{16{sh[15]}}, sh[15:0]};
      OP_LHU:  return {16'h0, sh[15:0]};
      OP_LW:   return word;
      default: return '0;
    endcase
  endfunction

  function automatic void apply_store(input lsu_op_t op, input int wi,
                                      input logic [1:0] off, input data_t wd);
    case (op)
      OP_SB:   shadow[wi][{off, 3'b000} +: 8] = wd[7:0];
      OP_SH:   shadow[wi][{off, 3'b000} +: 16] = wd[15:0];
      OP_SW:   shadow[wi] = wd;
      default: ;
    endcase
  endfunction

  task automatic accept_request();
    expect_t     e;
    int          wi;
    int          line;
    logic [23:0] tag;
    wi     = int'(req_addr[9:2]);
    line   = wi % LINES;
    tag    = req_addr[31:8];
    e.op   = req_op;
    e.addr = req_addr;
    e.data = '0;
    e.ar   = 1'b0;
    if (req_op inside {OP_SB, OP_SH, OP_SW})
    begin
      apply_store(req_op, wi, req_addr[1:0], req_wdata);
      mvalid[line] = 1'b0;
    end
    else
    begin
      e.ar         = !(mvalid[line] && mtag[line] == tag);
      mvalid[line] = 1'b1;
      mtag[line]   = tag;
      e.data       = load_value(req_op, shadow[wi], req_addr[1:0]);
    end
    exp_q.push_back(e);
    sent++;
  endtask

  // the request in execute is the oldest one not yet presented
  task automatic count_ar();
    int owner;
    owner = resp_count + (resp_valid ? 1 : 0);
    if (owner < sent)
      ar_seen[owner]++;
    else
    begin
      $display("AR handshake at %0t with no request in flight", $time);
      errors++;
    end
  endtask

  task automatic check_response();
    expect_t e;
    if (exp_q.size() == 0)
    begin
      $display("response at %0t arrived with no request outstanding", $time);
      errors++;
    end
    else
    begin
      e = exp_q.pop_front();
      checks += 2;
      if (resp_rdata !== e.data)
      begin
        $display("[FAIL] %0t: op %0d addr %h expected %h got %h",
                 $time, e.op, e.addr, e.data, resp_rdata);
        errors++;
      end
      if (ar_seen[resp_count] != int'(e.ar))
      begin
        $display("[FAIL] %0t: op %0d addr %h expected %0d AR handshakes got %0d",
                 $time, e.op, e.addr, e.ar, ar_seen[resp_count]);
        errors++;
      end
    end
    resp_count++;
  endtask

  task automatic drive_next();
    logic [3:0] r;
    logic [3:0] w;
    logic [1:0] off;
    lsu_op_t    op;
    if (sent >= NUM_REQ || take_bits(2) == 0)
      req_valid <= 1'b0;
    else
    begin
      r = 4'(take_bits(4) % 13);
      case (r)
        0, 1:    op = OP_LB;
        2, 3:    op = OP_LBU;
        4, 5:    op = OP_LH;
        6, 7:    op = OP_LHU;
        8, 9:    op = OP_LW;
        10:      op = OP_SB;
        11:      op = OP_SH;
        default: op = OP_SW;
      endcase
      if (op inside {OP_LB, OP_LBU, OP_SB})
        off = 2'(take_bits(2));
      else if (op inside {OP_LH, OP_LHU, OP_SH})
        off = 2'(take_bits(1) << 1);
      else
        off = 2'd0;
      // four lines, four tags each
      w = 4'(take_bits(4));
      req_op    <= op;
      req_addr  <= {22'h0, w[3:2], 4'h0, w[1:0], off};
      req_wdata <= take_bits(32);
      req_valid <= 1'b1;
    end
  endtask

  always #(CLK_NS / 2) clk = ~clk;

  always @(posedge clk)
  begin
    delays <= 10'(take_bits(10));
    if (!reset_i)
    begin
      if (arvalid && arready)
        count_ar();
      if (hold_q && !resp_valid)
      begin
        $display("response valid dropped at %0t before it was taken", $time);
        errors++;
      end
      else if (hold_q && resp_rdata !== hold_data)
      begin
        $display("[FAIL] %0t: stalled response changed from %h to %h",
                 $time, hold_data, resp_rdata);
        errors++;
      end
      hold_q    = resp_valid && !resp_ready;
      hold_data = resp_rdata;
      if (resp_valid && resp_ready)
        check_response();
      if (req_valid && req_ready)
        accept_request();
      if (!req_valid || req_ready)
        drive_next();
      resp_ready <= |take_bits(2);
    end
  end

  initial
  begin
    clk        = 1'b0;
    reset_i    <= 1'b1;
    req_valid  <= 1'b0;
    req_op     <= OP_LW;
    req_addr   <= '0;
    req_wdata  <= '0;
    resp_ready <= 1'b0;
    delays     <= '0;
    lfsr_q     = 32'd82425;
    sent       = 0;
    resp_count = 0;
    errors     = 0;
    checks     = 0;
    hold_q     = 1'b0;
    hold_data  = '0;
    for (int i = 0; i < MEM_WORDS; i++)
      shadow[i] = fill_word(i);
    for (int i = 0; i < LINES; i++)
    begin
      mvalid[i] = 1'b0;
      mtag[i]   = '0;
    end
    for (int i = 0; i < NUM_REQ; i++)
      ar_seen[i] = 0;
    repeat (5) @(posedge clk);
    reset_i <= 1'b0;
    wait (sent == NUM_REQ && resp_count == NUM_REQ);
    // drain, catching any stray response
    repeat (20) @(posedge clk);
    if (resp_count != sent || exp_q.size() != 0)
    begin
      $display("%0d requests but %0d responses", sent, resp_count);
      errors++;
    end
    for (int i = 0; i < MEM_WORDS; i++)
    begin
      checks++;
      if (u_mem.mem[i] !== shadow[i])
      begin
        $display("[FAIL] %0t: memory word %0d expected %h got %h",
                 $time, i, shadow[i], u_mem.mem[i]);
        errors++;
      end
    end
    $display("checks: %0d, errors: %0d, requests: %0d, responses: %0d",
             checks, errors, sent, resp_count);
    if (errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

  initial
  begin
    #(LIMIT_CYC * CLK_NS);
    $display("timeout after %0d cycles with %0d of %0d responses, errors: %0d",
             LIMIT_CYC, resp_count, NUM_REQ, errors);
    $display("Some tests failed");
    $finish;
  end

endmodule
